// File: Makefile
# Verilator flow for the coherent interconnect testbench

VERILATOR ?= verilator
TOP       ?= ccu_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= sim passed
FAIL_MSG  ?= sim failed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Failure found in $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Run did not complete, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: compile.f
rtl/ccu_cfg_pkg.sv
rtl/ccu_bus_pkg.sv
rtl/core_port_demux.sv
rtl/shared_req_arbiter.sv
rtl/ccu_ctrl.sv
rtl/mem_arbiter.sv
rtl/ccu_top.sv
test/tb_clock_gen.sv
test/ccu_asserts.sv
test/ccu_tb.sv

// File: rtl/ccu_bus_pkg.sv
package ccu_bus_pkg;

  // Request from a core, single beat
  typedef struct packed {
    ccu_cfg_pkg::opcode_e                op;
    ccu_cfg_pkg::domain_e                domain;
    logic [ccu_cfg_pkg::AddrWidth-1:0] addr;
    logic [ccu_cfg_pkg::DataWidth-1:0] wdata;
  } core_req_t;

  typedef struct packed {
    logic [ccu_cfg_pkg::DataWidth-1:0] rdata;  // Zero for writes
  } core_rsp_t;

  // Snoop towards a core
  typedef struct packed {
    ccu_cfg_pkg::snoop_e                 snoop;
    logic [ccu_cfg_pkg::AddrWidth-1:0] addr;
  } snoop_req_t;

  typedef struct packed {
    logic                              has_data;  // Core holds the line
    logic [ccu_cfg_pkg::DataWidth-1:0] data;
  } snoop_rsp_t;

  // Memory side, tag names the source port
  typedef struct packed {
    logic [ccu_cfg_pkg::MemTagWidth-1:0] tag;
    ccu_cfg_pkg::opcode_e                  op;
    logic [ccu_cfg_pkg::AddrWidth-1:0]   addr;
    logic [ccu_cfg_pkg::DataWidth-1:0]   wdata;
  } mem_req_t;

  typedef struct packed {
    logic [ccu_cfg_pkg::MemTagWidth-1:0] tag;
    logic [ccu_cfg_pkg::DataWidth-1:0]   rdata;
  } mem_rsp_t;

endpackage

// File: rtl/ccu_cfg_pkg.sv
package ccu_cfg_pkg;

  localparam int AddrWidth    = 16;
  localparam int DataWidth    = 32;
  localparam int MaxCores     = 4;
  localparam int CoreIdxWidth = 2;
  localparam int MemTagWidth  = 3;  // Room for MaxCores plus the controller

  typedef enum logic {OP_READ, OP_WRITE} opcode_e;

  typedef enum logic {DOM_NON_SHARED, DOM_SHARED} domain_e;

  typedef enum logic {SNP_READ_SHARED, SNP_CLEAN_INVALID} snoop_e;

  // Coherency controller states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SNOOP_REQ,
    ST_SNOOP_RSP,
    ST_MEM_REQ,
    ST_MEM_RSP,
    ST_RESPOND
  } ctrl_state_e;

endpackage

// File: rtl/ccu_ctrl.sv
`timescale 1ns/1ns

module ccu_ctrl #(
  parameter int NoCores = 2
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  ccu_bus_pkg::core_req_t                ccu_req_i,
  input  logic                                  ccu_req_valid_i,
  output logic                                  ccu_req_ready_o,
  input  logic [ccu_cfg_pkg::CoreIdxWidth-1:0]  ccu_src_i,
  output ccu_bus_pkg::core_rsp_t                ccu_rsp_o,
  output logic                                  ccu_rsp_valid_o,
  input  logic                                  ccu_rsp_ready_i,
  output ccu_bus_pkg::snoop_req_t [NoCores-1:0] snp_req_o,
  output logic [NoCores-1:0]                    snp_req_valid_o,
  input  logic [NoCores-1:0]                    snp_req_ready_i,
  input  ccu_bus_pkg::snoop_rsp_t [NoCores-1:0] snp_rsp_i,
  input  logic [NoCores-1:0]                    snp_rsp_valid_i,
  output ccu_bus_pkg::mem_req_t                 mem_req_o,
  output logic                                  mem_req_valid_o,
  input  logic                                  mem_req_ready_i,
  input  ccu_bus_pkg::mem_rsp_t                 mem_rsp_i,
  input  logic                                  mem_rsp_valid_i,
  output logic                                  mem_rsp_ready_o
);

  localparam int DataW = ccu_cfg_pkg::DataWidth;

  ccu_cfg_pkg::ctrl_state_e             state_q;
  ccu_bus_pkg::core_req_t               req_q;
  logic [ccu_cfg_pkg::CoreIdxWidth-1:0] src_q;
  logic [NoCores-1:0]                   target;   // Every core but the source
  logic [NoCores-1:0]                   sent_q;   // Snoop accepted
  logic [NoCores-1:0]                   got_q;    // Snoop answered
  logic [NoCores-1:0]                   hit_q;    // Answered with data
  logic [NoCores-1:0]                   snp_fire;
  logic [NoCores-1:0]                   snp_in;
  logic [NoCores-1:0]                   snp_hit;
  logic [NoCores-1:0][DataW-1:0]        snp_data_q;
  logic [DataW-1:0]                     hit_data;
  logic [DataW-1:0]                     rdata_q;
  logic                                 is_write;

  assign is_write = (req_q.op == ccu_cfg_pkg::OP_WRITE);

  for (genvar i = 0; i < NoCores; i++) begin : gen_snoop
    assign target[i]          = (int'(src_q) != i);
    assign snp_req_o[i].snoop = is_write ? ccu_cfg_pkg::SNP_CLEAN_INVALID
                                         : ccu_cfg_pkg::SNP_READ_SHARED;
    assign snp_req_o[i].addr  = req_q.addr;
    assign snp_req_valid_o[i] = (state_q == ccu_cfg_pkg::ST_SNOOP_REQ) && target[i] && !sent_q[i];
    assign snp_fire[i]        = snp_req_valid_o[i] && snp_req_ready_i[i];
    assign snp_in[i]          = snp_rsp_valid_i[i] && target[i];
    assign snp_hit[i]         = snp_in[i] && snp_rsp_i[i].has_data;
  end

  // Lowest-indexed core with data wins
  always_comb begin
    hit_data = '0;
    for (int i = NoCores - 1; i >= 0; i--) begin
      if (hit_q[i])
        hit_data = snp_data_q[i];
    end
  end

  assign ccu_req_ready_o = (state_q == ccu_cfg_pkg::ST_IDLE);
  assign ccu_rsp_valid_o = (state_q == ccu_cfg_pkg::ST_RESPOND);
  assign ccu_rsp_o.rdata = rdata_q;
  assign mem_req_valid_o = (state_q == ccu_cfg_pkg::ST_MEM_REQ);
  assign mem_req_o       = '{tag: '0, op: req_q.op, addr: req_q.addr, wdata: req_q.wdata};
  assign mem_rsp_ready_o = (state_q == ccu_cfg_pkg::ST_MEM_RSP);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ccu_cfg_pkg::ST_IDLE;
      sent_q  <= '0;
      got_q   <= '0;
      hit_q   <= '0;
    end else begin
      sent_q <= sent_q | snp_fire;
      got_q  <= got_q | snp_in;
      hit_q  <= hit_q | snp_hit;
      case (state_q)
        ccu_cfg_pkg::ST_IDLE: begin
          if (ccu_req_valid_i) begin
            state_q <= ccu_cfg_pkg::ST_SNOOP_REQ;
            sent_q  <= '0;
            got_q   <= '0;
            hit_q   <= '0;
          end
        end
        ccu_cfg_pkg::ST_SNOOP_REQ: begin
          if ((sent_q | snp_fire) == target)
            state_q <= ccu_cfg_pkg::ST_SNOOP_RSP;
        end
        ccu_cfg_pkg::ST_SNOOP_RSP: begin
          if (got_q == target)  // Memory skipped on a read hit
            state_q <= (!is_write && |hit_q) ? ccu_cfg_pkg::ST_RESPOND : ccu_cfg_pkg::ST_MEM_REQ;
        end
        ccu_cfg_pkg::ST_MEM_REQ: begin
          if (mem_req_ready_i)
            state_q <= ccu_cfg_pkg::ST_MEM_RSP;
        end
        ccu_cfg_pkg::ST_MEM_RSP: begin
          if (mem_rsp_valid_i)
            state_q <= ccu_cfg_pkg::ST_RESPOND;
        end
        ccu_cfg_pkg::ST_RESPOND: begin
          if (ccu_rsp_ready_i)
            state_q <= ccu_cfg_pkg::ST_IDLE;
        end
        default: state_q <= ccu_cfg_pkg::ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (ccu_req_valid_i && ccu_req_ready_o) begin
      req_q <= ccu_req_i;
      src_q <= ccu_src_i;
    end
    for (int i = 0; i < NoCores; i++) begin
      if (snp_in[i])
        snp_data_q[i] <= snp_rsp_i[i].data;
    end
    if (state_q == ccu_cfg_pkg::ST_SNOOP_RSP)
      rdata_q <= hit_data;
    if (mem_rsp_valid_i && mem_rsp_ready_o)
      rdata_q <= is_write ? '0 : mem_rsp_i.rdata;  // Writes answer zero
  end

endmodule

// File: rtl/ccu_top.sv
`timescale 1ns/1ns

module ccu_top #(
  parameter int NoCores = 2  // 2 up to MaxCores
) (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  ccu_bus_pkg::core_req_t  [NoCores-1:0] core_req_i,
  input  logic [NoCores-1:0]                    core_req_valid_i,
  output logic [NoCores-1:0]                    core_req_ready_o,
  output ccu_bus_pkg::core_rsp_t  [NoCores-1:0] core_rsp_o,
  output logic [NoCores-1:0]                    core_rsp_valid_o,
  input  logic [NoCores-1:0]                    core_rsp_ready_i,
  output ccu_bus_pkg::snoop_req_t [NoCores-1:0] snp_req_o,
  output logic [NoCores-1:0]                    snp_req_valid_o,
  input  logic [NoCores-1:0]                    snp_req_ready_i,
  input  ccu_bus_pkg::snoop_rsp_t [NoCores-1:0] snp_rsp_i,
  input  logic [NoCores-1:0]                    snp_rsp_valid_i,
  output ccu_bus_pkg::mem_req_t                 mem_req_o,
  output logic                                  mem_req_valid_o,
  input  logic                                  mem_req_ready_i,
  input  ccu_bus_pkg::mem_rsp_t                 mem_rsp_i,
  input  logic                                  mem_rsp_valid_i,
  output logic                                  mem_rsp_ready_o
);

  // Shareable path into the controller
  ccu_bus_pkg::core_req_t [NoCores-1:0] shr_reqs;
  logic [NoCores-1:0]                   shr_req_valid, shr_req_ready;
  ccu_bus_pkg::core_rsp_t [NoCores-1:0] shr_rsps;
  logic [NoCores-1:0]                   shr_rsp_valid, shr_rsp_ready;

  // Memory arbiter ports, index NoCores is the controller
  ccu_bus_pkg::mem_req_t [NoCores:0]    mem_reqs;
  logic [NoCores:0]                     mem_req_valid, mem_req_ready;
  ccu_bus_pkg::mem_rsp_t [NoCores:0]    mem_rsps;
  logic [NoCores:0]                     mem_rsp_valid, mem_rsp_ready;

  ccu_bus_pkg::core_req_t               ccu_req;
  logic                                 ccu_req_valid, ccu_req_ready;
  logic [ccu_cfg_pkg::CoreIdxWidth-1:0] ccu_src;
  ccu_bus_pkg::core_rsp_t               ccu_rsp;
  logic                                 ccu_rsp_valid, ccu_rsp_ready;

  for (genvar i = 0; i < NoCores; i++) begin : gen_core_demux
    core_port_demux i_core_port_demux (
      .clk_i              (clk_i),
      .reset_i            (reset_i),
      .slv_req_i          (core_req_i[i]),
      .slv_req_valid_i    (core_req_valid_i[i]),
      .slv_req_ready_o    (core_req_ready_o[i]),
      .slv_rsp_o          (core_rsp_o[i]),
      .slv_rsp_valid_o    (core_rsp_valid_o[i]),
      .slv_rsp_ready_i    (core_rsp_ready_i[i]),
      .direct_req_o       (mem_reqs[i]),
      .direct_req_valid_o (mem_req_valid[i]),
      .direct_req_ready_i (mem_req_ready[i]),
      .direct_rsp_i       (mem_rsps[i]),
      .direct_rsp_valid_i (mem_rsp_valid[i]),
      .direct_rsp_ready_o (mem_rsp_ready[i]),
      .shared_req_o       (shr_reqs[i]),
      .shared_req_valid_o (shr_req_valid[i]),
      .shared_req_ready_i (shr_req_ready[i]),
      .shared_rsp_i       (shr_rsps[i]),
      .shared_rsp_valid_i (shr_rsp_valid[i]),
      .shared_rsp_ready_o (shr_rsp_ready[i])
    );
  end

  shared_req_arbiter #(
    .NoCores (NoCores)
  ) i_shared_req_arbiter (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .slv_reqs_i       (shr_reqs),
    .slv_reqs_valid_i (shr_req_valid),
    .slv_reqs_ready_o (shr_req_ready),
    .slv_rsps_o       (shr_rsps),
    .slv_rsps_valid_o (shr_rsp_valid),
    .slv_rsps_ready_i (shr_rsp_ready),
    .ccu_req_o        (ccu_req),
    .ccu_req_valid_o  (ccu_req_valid),
    .ccu_req_ready_i  (ccu_req_ready),
    .ccu_src_o        (ccu_src),
    .ccu_rsp_i        (ccu_rsp),
    .ccu_rsp_valid_i  (ccu_rsp_valid),
    .ccu_rsp_ready_o  (ccu_rsp_ready)
  );

  ccu_ctrl #(
    .NoCores (NoCores)
  ) i_ccu_ctrl (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .ccu_req_i       (ccu_req),
    .ccu_req_valid_i (ccu_req_valid),
    .ccu_req_ready_o (ccu_req_ready),
    .ccu_src_i       (ccu_src),
    .ccu_rsp_o       (ccu_rsp),
    .ccu_rsp_valid_o (ccu_rsp_valid),
    .ccu_rsp_ready_i (ccu_rsp_ready),
    .snp_req_o       (snp_req_o),
    .snp_req_valid_o (snp_req_valid_o),
    .snp_req_ready_i (snp_req_ready_i),
    .snp_rsp_i       (snp_rsp_i),
    .snp_rsp_valid_i (snp_rsp_valid_i),
    .mem_req_o       (mem_reqs[NoCores]),
    .mem_req_valid_o (mem_req_valid[NoCores]),
    .mem_req_ready_i (mem_req_ready[NoCores]),
    .mem_rsp_i       (mem_rsps[NoCores]),
    .mem_rsp_valid_i (mem_rsp_valid[NoCores]),
    .mem_rsp_ready_o (mem_rsp_ready[NoCores])
  );

  mem_arbiter #(
    .NoCores (NoCores)
  ) i_mem_arbiter (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .slv_reqs_i       (mem_reqs),
    .slv_reqs_valid_i (mem_req_valid),
    .slv_reqs_ready_o (mem_req_ready),
    .slv_rsps_o       (mem_rsps),
    .slv_rsps_valid_o (mem_rsp_valid),
    .slv_rsps_ready_i (mem_rsp_ready),
    .mem_req_o        (mem_req_o),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_ready_i  (mem_req_ready_i),
    .mem_rsp_i        (mem_rsp_i),
    .mem_rsp_valid_i  (mem_rsp_valid_i),
    .mem_rsp_ready_o  (mem_rsp_ready_o)
  );

endmodule

// File: rtl/core_port_demux.sv
`timescale 1ns/1ns

module core_port_demux (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  ccu_bus_pkg::core_req_t slv_req_i,
  input  logic                   slv_req_valid_i,
  output logic                   slv_req_ready_o,
  output ccu_bus_pkg::core_rsp_t slv_rsp_o,
  output logic                   slv_rsp_valid_o,
  input  logic                   slv_rsp_ready_i,
  output ccu_bus_pkg::mem_req_t  direct_req_o,
  output logic                   direct_req_valid_o,
  input  logic                   direct_req_ready_i,
  input  ccu_bus_pkg::mem_rsp_t  direct_rsp_i,
  input  logic                   direct_rsp_valid_i,
  output logic                   direct_rsp_ready_o,
  output ccu_bus_pkg::core_req_t shared_req_o,
  output logic                   shared_req_valid_o,
  input  logic                   shared_req_ready_i,
  input  ccu_bus_pkg::core_rsp_t shared_rsp_i,
  input  logic                   shared_rsp_valid_i,
  output logic                   shared_rsp_ready_o
);

  logic pending_q;  // Response still outstanding
  logic route_q;    // Set when the outstanding request went to the shared path
  logic is_shared;

  assign is_shared = (slv_req_i.domain == ccu_cfg_pkg::DOM_SHARED);

  // Same payload on both paths, only one valid rises
  assign shared_req_o = slv_req_i;
  assign direct_req_o = '{
    tag:   '0,
    op:    slv_req_i.op,
    addr:  slv_req_i.addr,
    wdata: slv_req_i.wdata
  };
  assign direct_req_valid_o = slv_req_valid_i && !pending_q && !is_shared;
  assign shared_req_valid_o = slv_req_valid_i && !pending_q && is_shared;
  assign slv_req_ready_o    = !pending_q && (is_shared ? shared_req_ready_i : direct_req_ready_i);

  // Response only from the path the request took
  assign slv_rsp_o.rdata    = route_q ? shared_rsp_i.rdata : direct_rsp_i.rdata;
  assign slv_rsp_valid_o    = pending_q && (route_q ? shared_rsp_valid_i : direct_rsp_valid_i);
  assign direct_rsp_ready_o = pending_q && !route_q && slv_rsp_ready_i;
  assign shared_rsp_ready_o = pending_q && route_q && slv_rsp_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= 1'b0;
      route_q   <= 1'b0;
    end else if (slv_req_valid_i && slv_req_ready_o) begin
      pending_q <= 1'b1;
      route_q   <= is_shared;
    end else if (slv_rsp_valid_o && slv_rsp_ready_i) begin
      pending_q <= 1'b0;
    end
  end

endmodule

// File: rtl/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter #(
  parameter int NoCores = 2
) (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  ccu_bus_pkg::mem_req_t [NoCores:0]  slv_reqs_i,  // Last entry is the controller
  input  logic [NoCores:0]                   slv_reqs_valid_i,
  output logic [NoCores:0]                   slv_reqs_ready_o,
  output ccu_bus_pkg::mem_rsp_t [NoCores:0]  slv_rsps_o,
  output logic [NoCores:0]                   slv_rsps_valid_o,
  input  logic [NoCores:0]                   slv_rsps_ready_i,
  output ccu_bus_pkg::mem_req_t              mem_req_o,
  output logic                               mem_req_valid_o,
  input  logic                               mem_req_ready_i,
  input  ccu_bus_pkg::mem_rsp_t              mem_rsp_i,
  input  logic                               mem_rsp_valid_i,
  output logic                               mem_rsp_ready_o
);

  localparam int NoSrc = NoCores + 1;
  localparam int TagW  = ccu_cfg_pkg::MemTagWidth;

  logic [TagW-1:0] rr_q;
  logic [TagW-1:0] pick;
  logic [TagW-1:0] grant;
  logic [TagW-1:0] hold_idx_q;
  logic            hold_q;  // Grant frozen while memory stalls
  logic            any_valid;

  always_comb begin
    int unsigned idx;
    any_valid = 1'b0;
    pick      = '0;
    for (int unsigned off = 0; off < NoSrc; off++) begin
      idx = (rr_q + off) % NoSrc;
      if (!any_valid && slv_reqs_valid_i[idx]) begin
        any_valid = 1'b1;
        pick      = TagW'(idx);
      end
    end
  end

  assign grant           = hold_q ? hold_idx_q : pick;
  assign mem_req_valid_o = any_valid;

  always_comb begin
    mem_req_o       = slv_reqs_i[grant];
    mem_req_o.tag   = grant;  // Source index travels with the request
    mem_rsp_ready_o = 1'b0;
    for (int i = 0; i < NoSrc; i++) begin
      slv_reqs_ready_o[i] = any_valid && mem_req_ready_i && (int'(grant) == i);
      slv_rsps_o[i]       = mem_rsp_i;
      slv_rsps_valid_o[i] = mem_rsp_valid_i && (int'(mem_rsp_i.tag) == i);
      if (int'(mem_rsp_i.tag) == i)
        mem_rsp_ready_o = slv_rsps_ready_i[i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q       <= '0;
      hold_q     <= 1'b0;
      hold_idx_q <= '0;
    end else begin
      hold_q     <= any_valid && !mem_req_ready_i;
      hold_idx_q <= grant;
      if (any_valid && mem_req_ready_i)
        rr_q <= (int'(grant) == NoCores) ? '0 : grant + 1'b1;
    end
  end

endmodule

// File: rtl/shared_req_arbiter.sv
`timescale 1ns/1ns

module shared_req_arbiter #(
  parameter int NoCores = 2
) (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  ccu_bus_pkg::core_req_t [NoCores-1:0] slv_reqs_i,
  input  logic [NoCores-1:0]                   slv_reqs_valid_i,
  output logic [NoCores-1:0]                   slv_reqs_ready_o,
  output ccu_bus_pkg::core_rsp_t [NoCores-1:0] slv_rsps_o,
  output logic [NoCores-1:0]                   slv_rsps_valid_o,
  input  logic [NoCores-1:0]                   slv_rsps_ready_i,
  output ccu_bus_pkg::core_req_t               ccu_req_o,
  output logic                                 ccu_req_valid_o,
  input  logic                                 ccu_req_ready_i,
  output logic [ccu_cfg_pkg::CoreIdxWidth-1:0] ccu_src_o,
  input  ccu_bus_pkg::core_rsp_t               ccu_rsp_i,
  input  logic                                 ccu_rsp_valid_i,
  output logic                                 ccu_rsp_ready_o
);

  localparam int IdxW = ccu_cfg_pkg::CoreIdxWidth;

  logic [IdxW-1:0] rr_q;     // Highest priority core
  logic [IdxW-1:0] owner_q;  // Core being served by the controller
  logic [IdxW-1:0] pick;
  logic [IdxW-1:0] sel;
  logic            lock_q;
  logic            any_valid;

  // First valid core at or after the pointer
  always_comb begin
    int unsigned idx;
    any_valid = 1'b0;
    pick      = '0;
    for (int unsigned off = 0; off < NoCores; off++) begin
      idx = (rr_q + off) % NoCores;
      if (!any_valid && slv_reqs_valid_i[idx]) begin
        any_valid = 1'b1;
        pick      = IdxW'(idx);
      end
    end
  end

  assign sel             = lock_q ? owner_q : pick;
  assign ccu_src_o       = sel;
  assign ccu_req_o       = slv_reqs_i[sel];
  assign ccu_req_valid_o = !lock_q && any_valid;

  always_comb begin
    ccu_rsp_ready_o = 1'b0;
    for (int i = 0; i < NoCores; i++) begin
      slv_rsps_o[i]       = ccu_rsp_i;
      slv_reqs_ready_o[i] = ccu_req_valid_o && ccu_req_ready_i && (int'(pick) == i);
      slv_rsps_valid_o[i] = lock_q && ccu_rsp_valid_i && (int'(owner_q) == i);
      if (lock_q && int'(owner_q) == i)
        ccu_rsp_ready_o = slv_rsps_ready_i[i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q    <= '0;
      owner_q <= '0;
      lock_q  <= 1'b0;
    end else if (ccu_req_valid_o && ccu_req_ready_i) begin
      lock_q  <= 1'b1;
      owner_q <= pick;
    end else if (ccu_rsp_valid_i && ccu_rsp_ready_o) begin
      lock_q <= 1'b0;
      rr_q   <= (int'(owner_q) == NoCores - 1) ? '0 : owner_q + 1'b1;  // Past the winner
    end
  end

endmodule

// File: test/ccu_asserts.sv
`timescale 1ns/1ns

module ccu_asserts #(
  parameter int NoCores = 2
) (
  input logic                                  clk_i,
  input logic                                  reset_i,
  input logic [NoCores-1:0]                    core_req_valid_i,
  input logic [NoCores-1:0]                    core_req_ready_i,
  input logic [NoCores-1:0]                    core_rsp_valid_i,
  input logic [NoCores-1:0]                    core_rsp_ready_i,
  input ccu_bus_pkg::snoop_req_t [NoCores-1:0] snp_req_i,
  input logic [NoCores-1:0]                    snp_req_valid_i,
  input ccu_bus_pkg::snoop_rsp_t [NoCores-1:0] snp_rsp_i,
  input logic [NoCores-1:0]                    snp_rsp_valid_i,
  input ccu_bus_pkg::mem_req_t                 mem_req_i,
  input logic                                  mem_req_valid_i,
  input logic [ccu_cfg_pkg::CoreIdxWidth-1:0]  ccu_src_i,
  input logic                                  ccu_rsp_valid_i,
  input logic                                  ccu_rsp_ready_i
);

  logic [NoCores-1:0] pending_q;   // Core waits for its response
  logic               read_hit_q;  // A read snoop came back with data
  logic [NoCores-1:0] snp_read_hit;
  logic [NoCores-1:0] src_onehot;
  logic               ctrl_mem_req;

  for (genvar i = 0; i < NoCores; i++) begin : gen_hit
    assign snp_read_hit[i] = snp_rsp_valid_i[i] && snp_rsp_i[i].has_data &&
                             (snp_req_i[i].snoop == ccu_cfg_pkg::SNP_READ_SHARED);
  end

  assign src_onehot   = NoCores'(1) << ccu_src_i;
  assign ctrl_mem_req = mem_req_valid_i && (int'(mem_req_i.tag) == NoCores);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q  <= '0;
      read_hit_q <= 1'b0;
    end else begin
      for (int i = 0; i < NoCores; i++) begin
        if (core_req_valid_i[i] && core_req_ready_i[i])
          pending_q[i] <= 1'b1;
        else if (core_rsp_valid_i[i] && core_rsp_ready_i[i])
          pending_q[i] <= 1'b0;
      end
      if (ccu_rsp_valid_i && ccu_rsp_ready_i)
        read_hit_q <= 1'b0;  // Transaction over
      else if (|snp_read_hit)
        read_hit_q <= 1'b1;
    end
  end

  no_mem_on_read_hit: assert property (@(posedge clk_i) disable iff (reset_i)
    read_hit_q |-> !ctrl_mem_req)
    else $error("Controller issued a memory request after a snoop hit");

  no_self_snoop: assert property (@(posedge clk_i) disable iff (reset_i)
    |snp_req_valid_i |-> !(|(snp_req_valid_i & src_onehot)))
    else $error("Requesting core was snooped by its own request");

  quiet_after_reset: assert property (@(posedge clk_i)
    reset_i |=> !(|core_rsp_valid_i) && !(|snp_req_valid_i) && !mem_req_valid_i)
    else $error("A valid output was high right after reset");

  for (genvar i = 0; i < NoCores; i++) begin : gen_pending
    no_accept_while_pending: assert property (@(posedge clk_i) disable iff (reset_i)
      pending_q[i] |-> !core_req_ready_i[i])
      else $error("Core request accepted while a response was pending");
  end

endmodule

bind ccu_top ccu_asserts #(
  .NoCores (NoCores)
) i_ccu_asserts (
  .clk_i            (clk_i),
  .reset_i          (reset_i),
  .core_req_valid_i (core_req_valid_i),
  .core_req_ready_i (core_req_ready_o),
  .core_rsp_valid_i (core_rsp_valid_o),
  .core_rsp_ready_i (core_rsp_ready_i),
  .snp_req_i        (snp_req_o),
  .snp_req_valid_i  (snp_req_valid_o),
  .snp_rsp_i        (snp_rsp_i),
  .snp_rsp_valid_i  (snp_rsp_valid_i),
  .mem_req_i        (mem_req_o),
  .mem_req_valid_i  (mem_req_valid_o),
  .ccu_src_i        (ccu_src),
  .ccu_rsp_valid_i  (ccu_rsp_valid),
  .ccu_rsp_ready_i  (ccu_rsp_ready)
);

// File: test/ccu_tb.sv
`timescale 1ns/1ns

module ccu_tb;

  localparam int NoCores       = 2;
  localparam int ResetCycles   = 16;
  localparam int NumTests      = 6;
  localparam int CyclesPerTest = 200;

  logic clk;
  logic reset;

  ccu_bus_pkg::core_req_t  [NoCores-1:0] core_req;
  logic [NoCores-1:0]                    core_req_valid;
  logic [NoCores-1:0]                    core_req_ready;
  ccu_bus_pkg::core_rsp_t  [NoCores-1:0] core_rsp;
  logic [NoCores-1:0]                    core_rsp_valid;
  logic [NoCores-1:0]                    core_rsp_ready;
  ccu_bus_pkg::snoop_req_t [NoCores-1:0] snp_req;
  logic [NoCores-1:0]                    snp_req_valid;
  logic [NoCores-1:0]                    snp_req_ready;
  ccu_bus_pkg::snoop_rsp_t [NoCores-1:0] snp_rsp;
  logic [NoCores-1:0]                    snp_rsp_valid;
  ccu_bus_pkg::mem_req_t                 mem_req;
  logic                                  mem_req_valid;
  logic                                  mem_req_ready;
  ccu_bus_pkg::mem_rsp_t                 mem_rsp;
  logic                                  mem_rsp_valid;
  logic                                  mem_rsp_ready;

  int seed = 59232;

  logic [31:0]           mem_store [logic [15:0]];  // Only written words
  ccu_bus_pkg::mem_rsp_t rsp_queue [$];
  int                    snp_wait  [NoCores];       // Cycles until the snoop answer
  logic [15:0]           snp_addr  [NoCores];
  ccu_cfg_pkg::snoop_e   snp_last  [NoCores];
  int                    snp_count [NoCores];

  tb_clock_gen #(
    .PeriodNs    (100),
    .ResetCycles (ResetCycles)
  ) i_clock_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  ccu_top #(
    .NoCores (NoCores)
  ) dut0 (
    .clk_i            (clk),
    .reset_i          (reset),
    .core_req_i       (core_req),
    .core_req_valid_i (core_req_valid),
    .core_req_ready_o (core_req_ready),
    .core_rsp_o       (core_rsp),
    .core_rsp_valid_o (core_rsp_valid),
    .core_rsp_ready_i (core_rsp_ready),
    .snp_req_o        (snp_req),
    .snp_req_valid_o  (snp_req_valid),
    .snp_req_ready_i  (snp_req_ready),
    .snp_rsp_i        (snp_rsp),
    .snp_rsp_valid_i  (snp_rsp_valid),
    .mem_req_o        (mem_req),
    .mem_req_valid_o  (mem_req_valid),
    .mem_req_ready_i  (mem_req_ready),
    .mem_rsp_i        (mem_rsp),
    .mem_rsp_valid_i  (mem_rsp_valid),
    .mem_rsp_ready_o  (mem_rsp_ready)
  );

  // Contents of a word that was never written
  function automatic logic [31:0] mem_pattern(input logic [15:0] addr);
    return {16'h0000, addr} ^ 32'h5A5A0000;
  endfunction

  function automatic logic [31:0] snoop_data(input int core, input logic [15:0] addr);
    return ~{16'h0000, addr} ^ 32'(core);
  endfunction

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
      else stop_with_failure($sformatf("Mismatch in %s: expected %h, actual %h",
                                       name, expected, actual));
  endtask

  // One request from a core, returns the response data
  task automatic run_request(input int core, input ccu_cfg_pkg::opcode_e op,
                             input ccu_cfg_pkg::domain_e domain, input logic [15:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
    @(posedge clk);
    #5;
    core_req[core]       = '{op: op, domain: domain, addr: addr, wdata: wdata};
    core_req_valid[core] = 1'b1;
    do @(negedge clk); while (!core_req_ready[core]);
    @(posedge clk);
    #5;
    core_req_valid[core] = 1'b0;
    do @(negedge clk); while (!core_rsp_valid[core]);
    rdata = core_rsp[core].rdata;
    @(posedge clk);
  endtask

  // Memory with one cycle of latency
  initial begin : memory_model
    logic rsp_taken;
    mem_req_ready = 1'b1;
    mem_rsp       = '0;
    mem_rsp_valid = 1'b0;
    forever begin
      @(negedge clk);
      rsp_taken = mem_rsp_valid && mem_rsp_ready;
      if (mem_req_valid && mem_req_ready) begin
        if (mem_req.op == ccu_cfg_pkg::OP_WRITE) begin
          mem_store[mem_req.addr] = mem_req.wdata;
          rsp_queue.push_back('{tag: mem_req.tag, rdata: '0});
        end else if (mem_store.exists(mem_req.addr)) begin
          rsp_queue.push_back('{tag: mem_req.tag, rdata: mem_store[mem_req.addr]});
        end else begin
          rsp_queue.push_back('{tag: mem_req.tag, rdata: mem_pattern(mem_req.addr)});
        end
      end
      @(posedge clk);
      #5;
      if (rsp_taken)
        mem_rsp_valid = 1'b0;
      if (!mem_rsp_valid && rsp_queue.size() > 0) begin
        mem_rsp       = rsp_queue.pop_front();
        mem_rsp_valid = 1'b1;
      end
    end
  end

  // Cores hold data only where address bit 12 is set
  initial begin : snoop_model
    snp_req_ready = '1;
    snp_rsp       = '0;
    snp_rsp_valid = '0;
    for (int k = 0; k < NoCores; k++) begin
      snp_wait[k]  = 0;
      snp_addr[k]  = '0;
      snp_last[k]  = ccu_cfg_pkg::SNP_READ_SHARED;
      snp_count[k] = 0;
    end
    forever begin
      @(negedge clk);
      for (int k = 0; k < NoCores; k++) begin
        if (snp_req_valid[k] && snp_req_ready[k]) begin
          snp_addr[k]  = snp_req[k].addr;
          snp_last[k]  = snp_req[k].snoop;
          snp_count[k] = snp_count[k] + 1;
          snp_wait[k]  = 1 + int'($unsigned($random(seed)) % 32'd3);  // 1 to 3 cycles
        end
      end
      @(posedge clk);
      #5;
      for (int k = 0; k < NoCores; k++) begin
        snp_rsp_valid[k] = 1'b0;
        if (snp_wait[k] > 0) begin
          snp_wait[k] = snp_wait[k] - 1;
          if (snp_wait[k] == 0) begin
            snp_rsp[k]       = '{has_data: snp_addr[k][12], data: snoop_data(k, snp_addr[k])};
            snp_rsp_valid[k] = 1'b1;
          end
        end
      end
    end
  end

  initial begin : watchdog
    repeat (ResetCycles + NumTests * CyclesPerTest) @(posedge clk);
    stop_with_failure("Timeout: the tests did not finish in time");
  end

  initial begin : main_sequence
    logic [31:0] rdata;
    logic [31:0] rdata_b;
    logic [15:0] addr;
    int          snoops_before;
    core_req       = '0;
    core_req_valid = '0;
    core_rsp_ready = '1;
    @(negedge reset);

    // Direct reads from every core
    for (int c = 0; c < NoCores; c++) begin
      addr = 16'h0100 + 16'(c * 16);
      run_request(c, ccu_cfg_pkg::OP_READ, ccu_cfg_pkg::DOM_NON_SHARED, addr, '0, rdata);
      check_value($sformatf("nonshared_read_core%0d", c), mem_pattern(addr), rdata);
    end

    run_request(0, ccu_cfg_pkg::OP_WRITE, ccu_cfg_pkg::DOM_NON_SHARED, 16'h0200,
                32'hCAFE0001, rdata);
    run_request(1, ccu_cfg_pkg::OP_READ, ccu_cfg_pkg::DOM_NON_SHARED, 16'h0200, '0, rdata);
    check_value("nonshared_write_read", 32'hCAFE0001, rdata);

    run_request(0, ccu_cfg_pkg::OP_READ, ccu_cfg_pkg::DOM_SHARED, 16'h1040, '0, rdata);
    check_value("shared_read_hit", snoop_data(1, 16'h1040), rdata);

    run_request(1, ccu_cfg_pkg::OP_READ, ccu_cfg_pkg::DOM_SHARED, 16'h0480, '0, rdata);
    check_value("shared_read_miss", mem_pattern(16'h0480), rdata);

    // Shared write invalidates the other core, memory gets the data
    snoops_before = snp_count[1];
    run_request(0, ccu_cfg_pkg::OP_WRITE, ccu_cfg_pkg::DOM_SHARED, 16'h1280,
                32'h600DF00D, rdata);
    check_value("shared_write_rsp", 32'h0, rdata);
    assert (snp_count[1] > snoops_before)
      else stop_with_failure("Core 1 got no snoop for the shared write");
    check_value("shared_write_snoop", 32'(ccu_cfg_pkg::SNP_CLEAN_INVALID), 32'(snp_last[1]));
    run_request(1, ccu_cfg_pkg::OP_READ, ccu_cfg_pkg::DOM_NON_SHARED, 16'h1280, '0, rdata);
    check_value("shared_write_read", 32'h600DF00D, rdata);

    fork
      run_request(0, ccu_cfg_pkg::OP_READ, ccu_cfg_pkg::DOM_SHARED, 16'h1600, '0, rdata);
      run_request(1, ccu_cfg_pkg::OP_READ, ccu_cfg_pkg::DOM_SHARED, 16'h0660, '0, rdata_b);
    join
    check_value("concurrent_read_core0", snoop_data(1, 16'h1600), rdata);
    check_value("concurrent_read_core1", mem_pattern(16'h0660), rdata_b);

    $display("sim passed");
    $finish;
  end

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PeriodNs    = 100,
  parameter int ResetCycles = 16
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Release lands 5 ns after an edge, like the rest of the stimulus
  initial begin
    reset_o = 1'b1;
    repeat (ResetCycles) @(posedge clk_o);
    #5;
    reset_o = 1'b0;
  end

endmodule
